// ==== cpu_pkg.sv ====
package cpu_pkg;

	localparam int XLEN = 16;
	localparam int REG_NUM = 8;
	localparam int REG_AW = $clog2(REG_NUM);
	localparam int IMEM_DEPTH = 256;
	localparam int IMEM_AW = $clog2(IMEM_DEPTH);
	localparam int BOOT_WORDS = 64;
	localparam int BOOT_CNT_W = $clog2(BOOT_WORDS);
	localparam int FLASH_AW = 22;

	typedef logic [REG_AW-1:0] reg_addr_t;
	typedef logic [IMEM_AW-1:0] imem_addr_t;

	// Opcode lives in instruction bits 15..11
	typedef enum logic [4:0] {
		OP_NOP   = 5'h00,
		OP_LI    = 5'h01,
		OP_ADDIU = 5'h02,
		OP_ADDU  = 5'h03,
		OP_SUBU  = 5'h04,
		OP_AND   = 5'h05,
		OP_OR    = 5'h06,
		OP_SLT   = 5'h07,
		OP_LW    = 5'h08,
		OP_SW    = 5'h09,
		OP_BEQZ  = 5'h0a,
		OP_BNEZ  = 5'h0b,
		OP_B     = 5'h0c,
		OP_HALT  = 5'h1f
	} op_e;

	function automatic op_e inst_op(logic [XLEN-1:0] inst);
		return op_e'(inst[15:11]);
	endfunction

	function automatic reg_addr_t inst_rx(logic [XLEN-1:0] inst);
		return inst[10:8];
	endfunction

	function automatic reg_addr_t inst_ry(logic [XLEN-1:0] inst);
		return inst[7:5];
	endfunction

	function automatic reg_addr_t inst_rz(logic [XLEN-1:0] inst);
		return inst[4:2];
	endfunction

	function automatic logic [XLEN-1:0] imm8_sext(logic [XLEN-1:0] inst);
		return {{(XLEN-8){inst[7]}}, inst[7:0]};
	endfunction

	// Only LI takes its immediate unsigned
	function automatic logic [XLEN-1:0] imm8_zext(logic [XLEN-1:0] inst);
		return {{(XLEN-8){1'b0}}, inst[7:0]};
	endfunction

	function automatic logic [XLEN-1:0] imm5_sext(logic [XLEN-1:0] inst);
		return {{(XLEN-5){inst[4]}}, inst[4:0]};
	endfunction

	function automatic logic [XLEN-1:0] imm11_sext(logic [XLEN-1:0] inst);
		return {{(XLEN-11){inst[10]}}, inst[10:0]};
	endfunction

	typedef struct packed {
		logic [FLASH_AW-1:0] addr;
	} flash_req_t;

	typedef struct packed {
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] wdata;
		logic            write;
	} dmem_req_t;

	typedef struct packed {
		reg_addr_t       rd;
		logic [XLEN-1:0] value;
		logic [XLEN-1:0] pc;
	} wb_t;

	typedef struct packed {
		op_e             op;
		reg_addr_t       rd;
		logic            reg_write;
		logic [XLEN-1:0] op_a;
		logic [XLEN-1:0] op_b;
		logic [XLEN-1:0] store_data;
		logic [XLEN-1:0] pc;
	} id_exe_t;

endpackage

// ==== boot_loader.sv ====
module boot_loader (
	input  logic                     clk,
	input  logic                     arst_n,
	output logic                     flash_req_valid,
	output cpu_pkg::flash_req_t      flash_req,
	input  logic                     flash_ready,
	input  logic [cpu_pkg::XLEN-1:0] flash_rdata,
	output logic                     imem_we,
	output cpu_pkg::imem_addr_t      imem_waddr,
	output logic [cpu_pkg::XLEN-1:0] imem_wdata,
	output logic                     boot_done
);
	import cpu_pkg::*;

	typedef enum logic {
		BOOT_COPY,
		BOOT_DONE
	} boot_state_e;

	boot_state_e state;
	logic [BOOT_CNT_W-1:0] word_cnt;
	logic fire;
	logic last;

	assign fire = flash_req_valid && flash_ready;
	assign last = word_cnt == BOOT_CNT_W'(BOOT_WORDS - 1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= BOOT_COPY;
			word_cnt <= '0;
			flash_req_valid <= 1'b0;
		end else begin
			case (state)
				BOOT_COPY: begin
					// Request stays up until the final word is taken
					flash_req_valid <= !(fire && last);
					if (fire) begin
						word_cnt <= word_cnt + 1'b1;
						if (last) begin
							state <= BOOT_DONE;
						end
					end
				end
				default: flash_req_valid <= 1'b0;
			endcase
		end
	end

	assign flash_req.addr = FLASH_AW'(word_cnt);

	// Flash word k lands in imem word k
	assign imem_we = fire;
	assign imem_waddr = imem_addr_t'(word_cnt);
	assign imem_wdata = flash_rdata;
	assign boot_done = state == BOOT_DONE;

endmodule

// ==== imem.sv ====
module imem (
	input  logic                     clk,
	input  logic                     we,
	input  cpu_pkg::imem_addr_t      waddr,
	input  logic [cpu_pkg::XLEN-1:0] wdata,
	input  cpu_pkg::imem_addr_t      raddr,
	output logic [cpu_pkg::XLEN-1:0] rdata
);
	import cpu_pkg::*;

	logic [XLEN-1:0] mem [IMEM_DEPTH];

	// Written only by the boot loader
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Fetch sees the word in the same cycle
	assign rdata = mem[raddr];

endmodule

// ==== fetch_stage.sv ====
module fetch_stage (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     boot_done,
	input  logic                     hold,
	input  logic                     halt,
	input  logic                     redirect_valid,
	input  logic [cpu_pkg::XLEN-1:0] redirect_target,
	output cpu_pkg::imem_addr_t      imem_raddr,
	input  logic [cpu_pkg::XLEN-1:0] imem_rdata,
	output logic                     if_valid,
	output logic [cpu_pkg::XLEN-1:0] if_inst,
	output logic [cpu_pkg::XLEN-1:0] if_pc
);
	import cpu_pkg::*;

	logic [XLEN-1:0] pc;
	logic run;

	assign run = boot_done && !halt;
	assign imem_raddr = pc[IMEM_AW-1:0];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
			if_valid <= 1'b0;
		end else if (!hold) begin
			if_valid <= run;
			if (run) begin
				// Branch in decode; the word fetched now is its delay slot
				if (redirect_valid) begin
					pc <= redirect_target;
				end else begin
					pc <= pc + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!hold && run) begin
			if_inst <= imem_rdata;
			if_pc <= pc;
		end
	end

endmodule

// ==== decode_stage.sv ====
module decode_stage (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     hold,
	input  logic                     if_valid,
	input  logic [cpu_pkg::XLEN-1:0] if_inst,
	input  logic [cpu_pkg::XLEN-1:0] if_pc,
	output cpu_pkg::reg_addr_t       rs_addr_a,
	output cpu_pkg::reg_addr_t       rs_addr_b,
	input  logic [cpu_pkg::XLEN-1:0] rs_data_a,
	input  logic [cpu_pkg::XLEN-1:0] rs_data_b,
	input  logic                     exe_fwd_valid,
	input  cpu_pkg::reg_addr_t       exe_fwd_rd,
	input  logic [cpu_pkg::XLEN-1:0] exe_fwd_value,
	input  logic                     wb_valid,
	input  cpu_pkg::wb_t             wb,
	output logic                     redirect_valid,
	output logic [cpu_pkg::XLEN-1:0] redirect_target,
	output logic                     ex_valid,
	output cpu_pkg::id_exe_t         ex
);
	import cpu_pkg::*;

	op_e op;
	reg_addr_t rx;
	reg_addr_t ry;
	reg_addr_t rz;
	logic [XLEN-1:0] val_x;
	logic [XLEN-1:0] val_y;
	logic taken;
	id_exe_t ex_d;

	assign op = inst_op(if_inst);
	assign rx = inst_rx(if_inst);
	assign ry = inst_ry(if_inst);
	assign rz = inst_rz(if_inst);

	assign rs_addr_a = rx;
	assign rs_addr_b = ry;

	// Youngest producer wins
	always_comb begin
		if (exe_fwd_valid && exe_fwd_rd == rx) begin
			val_x = exe_fwd_value;
		end else if (wb_valid && wb.rd == rx) begin
			val_x = wb.value;
		end else begin
			val_x = rs_data_a;
		end
		if (exe_fwd_valid && exe_fwd_rd == ry) begin
			val_y = exe_fwd_value;
		end else if (wb_valid && wb.rd == ry) begin
			val_y = wb.value;
		end else begin
			val_y = rs_data_b;
		end
	end

	always_comb begin
		ex_d.op = op;
		ex_d.rd = rz;
		ex_d.reg_write = 1'b0;
		ex_d.op_a = val_x;
		ex_d.op_b = val_y;
		ex_d.store_data = val_y;
		ex_d.pc = if_pc;
		taken = 1'b0;
		redirect_target = if_pc + XLEN'(1) + imm8_sext(if_inst);
		case (op)
			OP_LI: begin
				ex_d.rd = rx;
				ex_d.reg_write = 1'b1;
				ex_d.op_b = imm8_zext(if_inst);
			end
			OP_ADDIU: begin
				ex_d.rd = rx;
				ex_d.reg_write = 1'b1;
				ex_d.op_b = imm8_sext(if_inst);
			end
			OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_SLT: ex_d.reg_write = 1'b1;
			OP_LW: begin
				ex_d.rd = ry;
				ex_d.reg_write = 1'b1;
				ex_d.op_b = imm5_sext(if_inst);
			end
			OP_SW: ex_d.op_b = imm5_sext(if_inst);
			OP_BEQZ: taken = val_x == '0;
			OP_BNEZ: taken = val_x != '0;
			OP_B: begin
				taken = 1'b1;
				redirect_target = if_pc + XLEN'(1) + imm11_sext(if_inst);
			end
			default: ;
		endcase
	end

	assign redirect_valid = if_valid && taken;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid <= 1'b0;
		end else if (!hold) begin
			ex_valid <= if_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			ex <= ex_d;
		end
	end

endmodule

// ==== reg_file.sv ====
module reg_file (
	input  logic                     clk,
	input  logic                     arst_n,
	input  cpu_pkg::reg_addr_t       raddr_a,
	input  cpu_pkg::reg_addr_t       raddr_b,
	output logic [cpu_pkg::XLEN-1:0] rdata_a,
	output logic [cpu_pkg::XLEN-1:0] rdata_b,
	input  logic                     we,
	input  cpu_pkg::reg_addr_t       waddr,
	input  logic [cpu_pkg::XLEN-1:0] wdata
);
	import cpu_pkg::*;

	logic [XLEN-1:0] regs [REG_NUM];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// Same-cycle writes are covered by forwarding in decode
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

endmodule

// ==== exe_stage.sv ====
module exe_stage (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     ex_valid,
	input  cpu_pkg::id_exe_t         ex,
	output logic                     dmem_req_valid,
	output cpu_pkg::dmem_req_t       dmem_req,
	input  logic                     dmem_ready,
	input  logic [cpu_pkg::XLEN-1:0] dmem_rdata,
	output logic                     hold,
	output logic                     halt,
	output logic                     exe_fwd_valid,
	output cpu_pkg::reg_addr_t       exe_fwd_rd,
	output logic [cpu_pkg::XLEN-1:0] exe_fwd_value,
	output logic                     wb_valid,
	output cpu_pkg::wb_t             wb
);
	import cpu_pkg::*;

	logic live;
	logic mem_op;
	logic [XLEN-1:0] alu_res;

	// Everything behind a HALT is squashed here
	assign live = ex_valid && !halt;
	assign mem_op = live && (ex.op == OP_LW || ex.op == OP_SW);

	always_comb begin
		alu_res = '0;
		case (ex.op)
			OP_LI: alu_res = ex.op_b;
			OP_ADDIU, OP_ADDU, OP_LW, OP_SW: alu_res = ex.op_a + ex.op_b;
			OP_SUBU: alu_res = ex.op_a - ex.op_b;
			OP_AND: alu_res = ex.op_a & ex.op_b;
			OP_OR: alu_res = ex.op_a | ex.op_b;
			OP_SLT: alu_res = XLEN'($signed(ex.op_a) < $signed(ex.op_b));
			default: ;
		endcase
	end

	assign dmem_req_valid = mem_op;
	assign dmem_req.addr = alu_res;
	assign dmem_req.wdata = ex.store_data;
	assign dmem_req.write = ex.op == OP_SW;

	// Whole pipeline waits on a slow data access
	assign hold = mem_op && !dmem_ready;

	assign exe_fwd_valid = live && ex.reg_write;
	assign exe_fwd_rd = ex.rd;
	assign exe_fwd_value = (ex.op == OP_LW) ? dmem_rdata : alu_res;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
			halt <= 1'b0;
		end else begin
			// One pulse per instruction, none while stalled
			wb_valid <= exe_fwd_valid && !hold;
			if (live && ex.op == OP_HALT) begin
				halt <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (exe_fwd_valid && !hold) begin
			wb.rd <= ex.rd;
			wb.value <= exe_fwd_value;
			wb.pc <= ex.pc;
		end
	end

endmodule

// ==== zhxpu.sv ====
module zhxpu (
	input  logic                     clk,
	input  logic                     arst_n,
	output logic                     flash_req_valid,
	output cpu_pkg::flash_req_t      flash_req,
	input  logic                     flash_ready,
	input  logic [cpu_pkg::XLEN-1:0] flash_rdata,
	output logic                     dmem_req_valid,
	output cpu_pkg::dmem_req_t       dmem_req,
	input  logic                     dmem_ready,
	input  logic [cpu_pkg::XLEN-1:0] dmem_rdata,
	output logic                     boot_done,
	output logic                     wb_valid,
	output cpu_pkg::wb_t             wb,
	output logic                     halted
);
	import cpu_pkg::*;

// Bootloader
	logic imem_we;
	imem_addr_t imem_waddr;
	logic [XLEN-1:0] imem_wdata;
	imem_addr_t imem_raddr;
	logic [XLEN-1:0] imem_rdata;

	boot_loader __boot_loader (
		.clk(clk),
		.arst_n(arst_n),
		.flash_req_valid(flash_req_valid),
		.flash_req(flash_req),
		.flash_ready(flash_ready),
		.flash_rdata(flash_rdata),
		.imem_we(imem_we),
		.imem_waddr(imem_waddr),
		.imem_wdata(imem_wdata),
		.boot_done(boot_done)
	);

	imem __imem (
		.clk(clk),
		.we(imem_we),
		.waddr(imem_waddr),
		.wdata(imem_wdata),
		.raddr(imem_raddr),
		.rdata(imem_rdata)
	);

// IF stage
	logic hold;
	logic redirect_valid;
	logic [XLEN-1:0] redirect_target;
	logic if_valid;
	logic [XLEN-1:0] if_inst;
	logic [XLEN-1:0] if_pc;

	fetch_stage __fetch_stage (
		.clk(clk),
		.arst_n(arst_n),
		.boot_done(boot_done),
		.hold(hold),
		.halt(halted),
		.redirect_valid(redirect_valid),
		.redirect_target(redirect_target),
		.imem_raddr(imem_raddr),
		.imem_rdata(imem_rdata),
		.if_valid(if_valid),
		.if_inst(if_inst),
		.if_pc(if_pc)
	);

// ID stage
	reg_addr_t rs_addr_a;
	reg_addr_t rs_addr_b;
	logic [XLEN-1:0] rs_data_a;
	logic [XLEN-1:0] rs_data_b;
	logic exe_fwd_valid;
	reg_addr_t exe_fwd_rd;
	logic [XLEN-1:0] exe_fwd_value;
	logic ex_valid;
	id_exe_t ex;

	decode_stage __decode_stage (
		.clk(clk),
		.arst_n(arst_n),
		.hold(hold),
		.if_valid(if_valid),
		.if_inst(if_inst),
		.if_pc(if_pc),
		.rs_addr_a(rs_addr_a),
		.rs_addr_b(rs_addr_b),
		.rs_data_a(rs_data_a),
		.rs_data_b(rs_data_b),
		.exe_fwd_valid(exe_fwd_valid),
		.exe_fwd_rd(exe_fwd_rd),
		.exe_fwd_value(exe_fwd_value),
		.wb_valid(wb_valid),
		.wb(wb),
		.redirect_valid(redirect_valid),
		.redirect_target(redirect_target),
		.ex_valid(ex_valid),
		.ex(ex)
	);

	// Write port is fed from the WB register
	reg_file __reg_file (
		.clk(clk),
		.arst_n(arst_n),
		.raddr_a(rs_addr_a),
		.raddr_b(rs_addr_b),
		.rdata_a(rs_data_a),
		.rdata_b(rs_data_b),
		.we(wb_valid),
		.waddr(wb.rd),
		.wdata(wb.value)
	);

// EXE and WB stages
	exe_stage __exe_stage (
		.clk(clk),
		.arst_n(arst_n),
		.ex_valid(ex_valid),
		.ex(ex),
		.dmem_req_valid(dmem_req_valid),
		.dmem_req(dmem_req),
		.dmem_ready(dmem_ready),
		.dmem_rdata(dmem_rdata),
		.hold(hold),
		.halt(halted),
		.exe_fwd_valid(exe_fwd_valid),
		.exe_fwd_rd(exe_fwd_rd),
		.exe_fwd_value(exe_fwd_value),
		.wb_valid(wb_valid),
		.wb(wb)
	);

endmodule

// ==== tb_zhxpu.sv ====
module tb_zhxpu;
	import cpu_pkg::*;

	localparam int NUM_TESTS = 6;
	localparam int FLASH_WAIT_MAX = 3;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * (BOOT_WORDS * (FLASH_WAIT_MAX + 1) + 200);

	logic clk;
	logic arst_n;
	logic flash_req_valid;
	flash_req_t flash_req;
	logic flash_ready = 1'b0;
	logic [XLEN-1:0] flash_rdata = '0;
	logic dmem_req_valid;
	dmem_req_t dmem_req;
	logic dmem_ready = 1'b0;
	logic [XLEN-1:0] dmem_rdata = '0;
	logic boot_done;
	logic wb_valid;
	wb_t wb;
	logic halted;

	logic [XLEN-1:0] prog [BOOT_WORDS];
	int prog_len;
	int flash_wait_max;
	int dmem_wait_max;
	int flash_wait;
	int dmem_wait;
	int flash_xfers;
	string test_name;
	wb_t got_q[$];
	wb_t exp_q[$];
	logic [XLEN-1:0] dmem_w [logic [XLEN-1:0]];
	logic [XLEN-1:0] exp_mem [logic [XLEN-1:0]];

	zhxpu dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		fail_run("Timeout: the tests did not finish in the expected time");
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	// Unwritten data memory words read back as this
	function automatic logic [XLEN-1:0] mem_pattern(input logic [XLEN-1:0] addr);
		return (addr * 16'h9e37) ^ 16'h3c5a;
	endfunction

	// Flash model, one word per ready pulse
	always @(negedge clk) begin
		if (!flash_req_valid) begin
			flash_ready = 1'b0;
			flash_wait = $urandom_range(flash_wait_max, 0);
		end else if (flash_wait == 0) begin
			if (flash_req.addr >= BOOT_WORDS) begin
				fail_run("Flash read beyond the end of the boot image");
			end else begin
				flash_ready = 1'b1;
				flash_rdata = prog[flash_req.addr];
				flash_xfers++;
				flash_wait = $urandom_range(flash_wait_max, 0);
			end
		end else begin
			flash_ready = 1'b0;
			flash_wait--;
		end
	end

	// Data memory model; the request is stable for the whole cycle
	always @(negedge clk) begin
		if (!dmem_req_valid) begin
			dmem_ready = 1'b0;
			dmem_wait = $urandom_range(dmem_wait_max, 0);
		end else if (dmem_wait == 0) begin
			dmem_ready = 1'b1;
			if (dmem_req.write) begin
				dmem_w[dmem_req.addr] = dmem_req.wdata;
			end else if (dmem_w.exists(dmem_req.addr)) begin
				dmem_rdata = dmem_w[dmem_req.addr];
			end else begin
				dmem_rdata = mem_pattern(dmem_req.addr);
			end
			dmem_wait = $urandom_range(dmem_wait_max, 0);
		end else begin
			dmem_ready = 1'b0;
			dmem_wait--;
		end
	end

	always @(negedge clk) begin
		if (arst_n && wb_valid) begin
			got_q.push_back(wb);
		end
	end

	function automatic logic [XLEN-1:0] imm_form(input op_e op, input logic [2:0] rx,
			input logic [7:0] imm);
		return {op, rx, imm};
	endfunction

	function automatic logic [XLEN-1:0] reg_form(input op_e op, input logic [2:0] rx,
			input logic [2:0] ry, input logic [2:0] rz);
		return {op, rx, ry, rz, 2'b00};
	endfunction

	function automatic logic [XLEN-1:0] mem_form(input op_e op, input logic [2:0] rx,
			input logic [2:0] ry, input logic [4:0] imm);
		return {op, rx, ry, imm};
	endfunction

	function automatic logic [XLEN-1:0] jump_form(input logic [10:0] off);
		return {OP_B, off};
	endfunction

	task automatic clear_program();
		foreach (prog[i]) begin
			prog[i] = '0;
		end
		prog_len = 0;
	endtask

	task automatic put(input logic [XLEN-1:0] inst);
		prog[prog_len] = inst;
		prog_len++;
	endtask

	task automatic check_wb(input wb_t exp, input wb_t got);
		if (got !== exp) begin
			fail_run($sformatf("Error %s: expected rd=%0d value=%h pc=%h, actual rd=%0d value=%h pc=%h",
				test_name, exp.rd, exp.value, exp.pc, got.rd, got.value, got.pc));
		end
	endtask

	task automatic check_word(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] exp,
			input logic [XLEN-1:0] got);
		if (got !== exp) begin
			fail_run($sformatf("Error %s: word at %h expected %h, actual %h",
				test_name, addr, exp, got));
		end
	endtask

	// Sequential reference model with one delay slot per branch
	task automatic predict_results();
		logic [XLEN-1:0] r [REG_NUM];
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] npc;
		logic [XLEN-1:0] next;
		logic [XLEN-1:0] inst;
		logic [XLEN-1:0] s8;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] res;
		logic [2:0] rx;
		logic [2:0] ry;
		logic [2:0] rz;
		int dest;
		logic done;
		wb_t item;
		exp_q.delete();
		exp_mem.delete();
		foreach (r[i]) begin
			r[i] = '0;
		end
		pc = '0;
		npc = 16'd1;
		done = 1'b0;
		for (int step = 0; step < 400 && !done; step++) begin
			inst = prog[pc[5:0]];
			rx = inst[10:8];
			ry = inst[7:5];
			rz = inst[4:2];
			s8 = {{8{inst[7]}}, inst[7:0]};
			addr = r[rx] + {{11{inst[4]}}, inst[4:0]};
			next = npc + 16'd1;
			dest = -1;
			res = '0;
			case (op_e'(inst[15:11]))
				OP_LI: begin
					dest = rx;
					res = {8'h00, inst[7:0]};
				end
				OP_ADDIU: begin
					dest = rx;
					res = r[rx] + s8;
				end
				OP_ADDU: begin
					dest = rz;
					res = r[rx] + r[ry];
				end
				OP_SUBU: begin
					dest = rz;
					res = r[rx] - r[ry];
				end
				OP_AND: begin
					dest = rz;
					res = r[rx] & r[ry];
				end
				OP_OR: begin
					dest = rz;
					res = r[rx] | r[ry];
				end
				OP_SLT: begin
					dest = rz;
					res = ($signed(r[rx]) < $signed(r[ry])) ? 16'd1 : 16'd0;
				end
				OP_LW: begin
					dest = ry;
					res = exp_mem.exists(addr) ? exp_mem[addr] : mem_pattern(addr);
				end
				OP_SW: exp_mem[addr] = r[ry];
				OP_BEQZ: next = (r[rx] == '0) ? pc + 16'd1 + s8 : next;
				OP_BNEZ: next = (r[rx] != '0) ? pc + 16'd1 + s8 : next;
				OP_B: next = pc + 16'd1 + {{5{inst[10]}}, inst[10:0]};
				OP_HALT: done = 1'b1;
				default: ;
			endcase
			if (dest >= 0) begin
				r[dest] = res;
				item.rd = reg_addr_t'(dest);
				item.value = res;
				item.pc = pc;
				exp_q.push_back(item);
			end
			pc = npc;
			npc = next;
		end
		if (!done) begin
			fail_run("Reference model found no HALT in the program");
		end
	endtask

	task automatic reset_dut();
		@(negedge clk);
		arst_n = 1'b0;
		got_q.delete();
		dmem_w.delete();
		flash_xfers = 0;
		repeat (5) @(negedge clk);
		if (flash_req_valid || dmem_req_valid || wb_valid || boot_done || halted) begin
			fail_run("An output of the DUT is not low while reset is held");
		end
		arst_n = 1'b1;
	endtask

	task automatic run_program(input string name, input int f_wait, input int d_wait);
		test_name = name;
		flash_wait_max = f_wait;
		dmem_wait_max = d_wait;
		predict_results();
		reset_dut();
		while (!boot_done) @(negedge clk);
		if (flash_xfers != BOOT_WORDS) begin
			fail_run($sformatf("Error %s: flash transfers expected %0d, actual %0d",
				name, BOOT_WORDS, flash_xfers));
		end
		while (!halted) @(negedge clk);
		// Quiet window; nothing may retire behind HALT
		repeat (8) @(negedge clk);
		if (!halted) begin
			fail_run("The halted output dropped after it was raised");
		end
		if (got_q.size() != exp_q.size()) begin
			fail_run($sformatf("Error %s: write-back count expected %0d, actual %0d",
				name, exp_q.size(), got_q.size()));
		end
		foreach (exp_q[i]) begin
			check_wb(exp_q[i], got_q[i]);
		end
		if (dmem_w.size() != exp_mem.size()) begin
			fail_run($sformatf("Error %s: stored word count expected %0d, actual %0d",
				name, exp_mem.size(), dmem_w.size()));
		end
		foreach (exp_mem[a]) begin
			if (!dmem_w.exists(a)) begin
				fail_run($sformatf("No store reached data memory address %h", a));
			end else begin
				check_word(a, exp_mem[a], dmem_w[a]);
			end
		end
		$display("%s: %0d write-backs checked", name, got_q.size());
	endtask

	task automatic test_arith();
		clear_program();
		put(imm_form(OP_LI, 3'd1, 8'h85));
		put(imm_form(OP_LI, 3'd2, 8'h13));
		put(imm_form(OP_ADDIU, 3'd1, 8'(-3)));
		put(reg_form(OP_ADDU, 3'd1, 3'd2, 3'd3));
		put(reg_form(OP_SUBU, 3'd2, 3'd1, 3'd4));
		put(reg_form(OP_AND, 3'd1, 3'd2, 3'd5));
		put(reg_form(OP_OR, 3'd1, 3'd2, 3'd6));
		put(reg_form(OP_SLT, 3'd4, 3'd2, 3'd7));
		put(reg_form(OP_SLT, 3'd2, 3'd4, 3'd0));
		put(imm_form(OP_LI, 3'd0, 8'hf0));
		put({OP_HALT, 11'd0});
		run_program("arith", 1, 0);
	endtask

	task automatic test_forward();
		clear_program();
		put(imm_form(OP_LI, 3'd1, 8'd5));
		put(imm_form(OP_ADDIU, 3'd1, 8'd1));
		put(reg_form(OP_ADDU, 3'd1, 3'd1, 3'd2));
		put(reg_form(OP_ADDU, 3'd2, 3'd1, 3'd3));
		put(reg_form(OP_SUBU, 3'd3, 3'd2, 3'd1));
		put(imm_form(OP_ADDIU, 3'd1, 8'(-1)));
		put(reg_form(OP_OR, 3'd1, 3'd3, 3'd4));
		put(reg_form(OP_AND, 3'd4, 3'd2, 3'd5));
		put(reg_form(OP_ADDU, 3'd5, 3'd4, 3'd5));
		put(reg_form(OP_SLT, 3'd5, 3'd1, 3'd6));
		put({OP_HALT, 11'd0});
		run_program("forward", 0, 0);
	endtask

	task automatic test_mem();
		clear_program();
		put(imm_form(OP_LI, 3'd1, 8'h40));
		put(imm_form(OP_LI, 3'd2, 8'hab));
		put(mem_form(OP_SW, 3'd1, 3'd2, 5'd3));
		put(mem_form(OP_LW, 3'd1, 3'd3, 5'd3));
		put(reg_form(OP_ADDU, 3'd3, 3'd3, 3'd4));
		put(mem_form(OP_LW, 3'd1, 3'd5, 5'(-2)));
		put(imm_form(OP_ADDIU, 3'd5, 8'd1));
		put(mem_form(OP_SW, 3'd1, 3'd5, 5'(-16)));
		put(mem_form(OP_SW, 3'd4, 3'd1, 5'd0));
		put(mem_form(OP_LW, 3'd4, 3'd6, 5'd0));
		// Address comes straight from the previous load
		put(mem_form(OP_LW, 3'd6, 3'd7, 5'd3));
		put({OP_HALT, 11'd0});
		run_program("mem", 1, 3);
	endtask

	task automatic test_branch();
		clear_program();
		put(imm_form(OP_LI, 3'd1, 8'd0));
		put(imm_form(OP_LI, 3'd2, 8'd3));
		put(imm_form(OP_BEQZ, 3'd1, 8'd2));
		put(imm_form(OP_ADDIU, 3'd2, 8'd1));
		put(imm_form(OP_LI, 3'd3, 8'h77));
		put(imm_form(OP_BNEZ, 3'd1, 8'd1));
		put(imm_form(OP_ADDIU, 3'd2, 8'd2));
		put(imm_form(OP_LI, 3'd4, 8'd9));
		put(imm_form(OP_BNEZ, 3'd4, 8'd2));
		put(imm_form(OP_LI, 3'd5, 8'd1));
		put(imm_form(OP_LI, 3'd6, 8'h66));
		put(imm_form(OP_BEQZ, 3'd4, 8'd1));
		put(imm_form(OP_LI, 3'd7, 8'd2));
		put(jump_form(11'd2));
		put(imm_form(OP_ADDIU, 3'd7, 8'd1));
		put(imm_form(OP_LI, 3'd0, 8'h55));
		// Backward loop, three passes
		put(imm_form(OP_LI, 3'd1, 8'd3));
		put(imm_form(OP_ADDIU, 3'd1, 8'(-1)));
		put(imm_form(OP_BNEZ, 3'd1, 8'(-2)));
		put(reg_form(OP_ADDU, 3'd1, 3'd7, 3'd6));
		put({OP_HALT, 11'd0});
		run_program("branch", 1, 0);
	endtask

	task automatic test_flash();
		clear_program();
		put(imm_form(OP_LI, 3'd1, 8'd5));
		put(imm_form(OP_LI, 3'd2, 8'd0));
		put(reg_form(OP_ADDU, 3'd2, 3'd1, 3'd2));
		put(imm_form(OP_ADDIU, 3'd1, 8'(-1)));
		put(imm_form(OP_BNEZ, 3'd1, 8'(-3)));
		put(16'h0000);
		put(jump_form(11'd53));
		put(16'h0000);
		// Tail of the image, only reachable through the jump
		prog_len = 60;
		put(imm_form(OP_LI, 3'd3, 8'hc3));
		put(reg_form(OP_ADDU, 3'd3, 3'd2, 3'd4));
		put({OP_HALT, 11'd0});
		put(imm_form(OP_LI, 3'd5, 8'h5e));
		run_program("flash", FLASH_WAIT_MAX, 2);
	endtask

	task automatic test_halt();
		clear_program();
		put(imm_form(OP_LI, 3'd1, 8'd1));
		put(imm_form(OP_ADDIU, 3'd1, 8'd1));
		put({OP_HALT, 11'd0});
		put(imm_form(OP_LI, 3'd2, 8'd9));
		put(imm_form(OP_ADDIU, 3'd1, 8'd5));
		put(mem_form(OP_SW, 3'd1, 3'd1, 5'd0));
		put(imm_form(OP_LI, 3'd3, 8'd3));
		run_program("halt", 2, 1);
	endtask

	initial begin
		void'($urandom(32'h7a0c));
		arst_n = 1'b0;
		test_arith();
		test_forward();
		test_mem();
		test_branch();
		test_flash();
		test_halt();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== src.f ====
cpu_pkg.sv
boot_loader.sv
imem.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
exe_stage.sv
zhxpu.sv
tb_zhxpu.sv

// ==== Bender.yml ====
package:
  name: zhxpu

sources:
  - cpu_pkg.sv
  - boot_loader.sv
  - imem.sv
  - fetch_stage.sv
  - decode_stage.sv
  - reg_file.sv
  - exe_stage.sv
  - zhxpu.sv
  - target: test
    files:
      - tb_zhxpu.sv
